/* Makefile */
# Verilator build and run of the CRTC testbench

VERILATOR ?= verilator
TOP       ?= crtc_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q ">>> FAIL" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q ">>> PASS" $(LOG) || { echo "No result in $(LOG)"; exit 1; }

lint:
	$(VERILATOR) --lint-only -Wall --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+include
source/crtc_regs_pkg.sv
source/crtc_timing_pkg.sv
source/crtc_reg_file.sv
source/crtc_horiz.sv
source/crtc_vert.sv
source/crtc_addr_gen.sv
source/crtc_top.sv
dv/crtc_tb.sv

/* dv/crtc_tb.sv */
// Directed testbench for the CRTC timing generator
// Checks the Wishbone registers, then programs a small layout and measures
// line, frame, display enable and refresh address timing from the outputs
// The monitor keeps only output samples that belong to a character tick

`default_nettype none

`include "crtc_cfg.svh"

module crtc_tb
    import crtc_regs_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int SEED       = 30;

    // Small layout under test
    localparam int H_TOTAL      = 11;
    localparam int H_DISPLAYED  = 6;
    localparam int H_SYNC_POS   = 8;
    localparam int H_SYNC_WIDTH = 2;
    localparam int V_SYNC_WIDTH = 2;
    localparam int V_TOTAL      = 4;
    localparam int V_ADJUST     = 1;
    localparam int V_DISPLAYED  = 3;
    localparam int V_SYNC_POS   = 3;
    localparam int MAX_SCAN     = 2;
    localparam logic [`CRTC_MA_WIDTH-1:0] START_ADDR = 14'h3FF0;   // Rows wrap past 14 bits

    localparam int LINE_TICKS  = H_TOTAL + 1;
    localparam int ROW_LINES   = (V_TOTAL + 1) * (MAX_SCAN + 1);
    localparam int FRAME_LINES = ROW_LINES + V_ADJUST;
    localparam int FRAME_TICKS = LINE_TICKS * FRAME_LINES;

    localparam int FRAMES_PER_TEST = 3;     // One to settle, two measured
    localparam int NUM_TESTS       = 5;
    localparam int TICK_CYCLES     = 4;     // Twice the mean enable spacing
    localparam int WATCHDOG_NS = FRAME_TICKS * FRAMES_PER_TEST * NUM_TESTS * TICK_CYCLES
                                 * CLK_PERIOD;

    typedef struct packed {
        logic                      hs;
        logic                      vs;
        logic                      de;
        logic [`CRTC_MA_WIDTH-1:0] ma;
        logic [`CRTC_RA_WIDTH-1:0] ra;
    } sample_t;

    logic                        wb_clock_i = 1'b0;
    logic                        reset_i;
    logic                        clk_en_i;
    logic                        wb_cyc_i;
    logic                        wb_stb_i;
    logic                        wb_we_i;
    logic [`CRTC_ADDR_WIDTH-1:0] wb_adr_i;
    logic [`CRTC_DATA_WIDTH-1:0] wb_dat_i;
    logic [`CRTC_DATA_WIDTH-1:0] wb_dat_o;
    logic                        wb_ack_o;
    logic                        h_sync_o;
    logic                        v_sync_o;
    logic                        de_o;
    logic [`CRTC_MA_WIDTH-1:0]   ma_o;
    logic [`CRTC_RA_WIDTH-1:0]   ra_o;

    bit        ticking    = 1'b0;
    bit        collecting = 1'b0;
    logic [2:0] en_pipe   = 3'b000;     // Enables of the last three cycles
    sample_t   samples[$];
    int        n_checks   = 0;
    int        n_errors   = 0;

    crtc_top dut0 (
        .wb_clock_i, .reset_i, .clk_en_i,
        .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o,
        .h_sync_o, .v_sync_o, .de_o, .ma_o, .ra_o
    );

    always #(CLK_PERIOD / 2) wb_clock_i = ~wb_clock_i;

    // Character clock enable on about every other cycle
    initial begin
        void'($urandom(SEED));
        clk_en_i = 1'b0;
        forever begin
            @(posedge wb_clock_i);
            clk_en_i <= ticking && ($urandom % 2 == 1);
        end
    end

    // Outputs at this point belong to the enable of three cycles ago
    always @(negedge wb_clock_i) begin
        if (en_pipe[2] && collecting) begin
            samples.push_back('{h_sync_o, v_sync_o, de_o, ma_o, ra_o});
        end
        en_pipe <= {en_pipe[1:0], clk_en_i};
    end

    function automatic logic [`CRTC_DATA_WIDTH-1:0] reset_value(input int adr);
        case (adr)
            0:       return `CRTC_R0_RESET;
            1:       return `CRTC_R1_RESET;
            2:       return `CRTC_R2_RESET;
            3:       return `CRTC_R3_RESET;
            4:       return `CRTC_R4_RESET;
            5:       return `CRTC_R5_RESET;
            6:       return `CRTC_R6_RESET;
            7:       return `CRTC_R7_RESET;
            9:       return `CRTC_R9_RESET;
            12:      return `CRTC_R12_RESET;
            13:      return `CRTC_R13_RESET;
            default: return 8'h00;
        endcase
    endfunction

    // Bits kept by each register slot
    function automatic logic [`CRTC_DATA_WIDTH-1:0] kept_bits(input int adr);
        case (adr)
            0, 1, 2, 3, 13: return 8'hFF;
            4, 6, 7:        return 8'h7F;
            5, 9:           return 8'h1F;
            12:             return 8'h3F;
            default:        return 8'h00;
        endcase
    endfunction

    task automatic check_reg(input string name, input logic [`CRTC_DATA_WIDTH-1:0] exp,
                             input logic [`CRTC_DATA_WIDTH-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s expected 8'h%h, got 8'h%h", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        n_checks++;
        if (act != exp) begin
            n_errors++;
            $display("Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`CRTC_MA_WIDTH-1:0] exp,
                              input logic [`CRTC_MA_WIDTH-1:0] act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("Error at %0t ns: %s expected 14'h%h, got 14'h%h", $time, name, exp, act);
        end
    endtask

    task automatic report_problem(input string msg);
        n_errors++;
        $display("%s", msg);
    endtask

    // Drop the strobe after ack, ack must be gone in the following cycle
    task automatic end_access();
        wb_cyc_i <= 1'b0;
        wb_stb_i <= 1'b0;
        wb_we_i  <= 1'b0;
        @(posedge wb_clock_i);
        check_count("wb_ack_o cycle after ack", 0, (wb_ack_o === 1'b0) ? 0 : 1);
    endtask

    task automatic wb_write(input logic [`CRTC_ADDR_WIDTH-1:0] adr,
                            input logic [`CRTC_DATA_WIDTH-1:0] data);
        @(posedge wb_clock_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b1;
        wb_adr_i <= adr;
        wb_dat_i <= data;
        do @(posedge wb_clock_i); while (!wb_ack_o);
        end_access();
    endtask

    task automatic wb_read(input logic [`CRTC_ADDR_WIDTH-1:0] adr,
                           output logic [`CRTC_DATA_WIDTH-1:0] data);
        @(posedge wb_clock_i);
        wb_cyc_i <= 1'b1;
        wb_stb_i <= 1'b1;
        wb_we_i  <= 1'b0;
        wb_adr_i <= adr;
        do @(posedge wb_clock_i); while (!wb_ack_o);
        data = wb_dat_o;        // Valid with ack
        end_access();
    endtask

    // Fresh queue of tick samples over several frames
    task automatic collect_frames(input int frames);
        samples.delete();
        collecting = 1'b1;
        while (samples.size() < frames * FRAME_TICKS) @(posedge wb_clock_i);
        collecting = 1'b0;
    endtask

    task automatic register_access();
        logic [`CRTC_DATA_WIDTH-1:0] data;
        for (int a = 0; a < `CRTC_REG_COUNT; a++) begin
            wb_read(4'(a), data);
            check_reg($sformatf("wb_dat_o reset R%0d", a), reset_value(a), data);
        end
        for (int a = 0; a < `CRTC_REG_COUNT; a++) begin
            wb_write(4'(a), 8'hFF);
            wb_read(4'(a), data);
            check_reg($sformatf("wb_dat_o masked R%0d", a), kept_bits(a), data);
        end
        wb_write(R3_SYNC_WIDTH, 8'hA5);     // Both nibbles are stored
        wb_read(R3_SYNC_WIDTH, data);
        check_reg("wb_dat_o R3 widths", 8'hA5, data);
    endtask

    task automatic program_layout();
        wb_write(R0_H_TOTAL, 8'(H_TOTAL));
        wb_write(R1_H_DISPLAYED, 8'(H_DISPLAYED));
        wb_write(R2_H_SYNC_POS, 8'(H_SYNC_POS));
        wb_write(R3_SYNC_WIDTH, {4'(V_SYNC_WIDTH), 4'(H_SYNC_WIDTH)});
        wb_write(R4_V_TOTAL, 8'(V_TOTAL));
        wb_write(R5_V_ADJUST, 8'(V_ADJUST));
        wb_write(R6_V_DISPLAYED, 8'(V_DISPLAYED));
        wb_write(R7_V_SYNC_POS, 8'(V_SYNC_POS));
        wb_write(R9_MAX_SCAN, 8'(MAX_SCAN));
        wb_write(R12_START_HI, {2'b00, START_ADDR[13:8]});
        wb_write(R13_START_LO, START_ADDR[7:0]);
    endtask

    task automatic line_timing();
        int last_rise;
        int periods;
        last_rise = -1;
        periods   = 0;
        collect_frames(FRAMES_PER_TEST);
        for (int i = 1; i < samples.size(); i++) begin
            if (samples[i].hs && !samples[i-1].hs) begin
                if (last_rise >= 0) begin
                    check_count("hsync period in ticks", LINE_TICKS, i - last_rise);
                    periods++;
                end
                last_rise = i;
            end else if (!samples[i].hs && samples[i-1].hs && last_rise >= 0) begin
                check_count("hsync width in ticks", H_SYNC_WIDTH, i - last_rise);
            end
        end
        if (periods == 0) report_problem("Line test saw fewer than two hsync pulses");
    endtask

    task automatic frame_timing();
        int  hs_rises;
        int  vs_lines;
        int  frames;
        bit  seen;
        hs_rises = 0;
        vs_lines = 0;
        frames   = 0;
        seen     = 1'b0;
        collect_frames(FRAMES_PER_TEST);
        for (int i = 1; i < samples.size(); i++) begin
            if (samples[i].hs && !samples[i-1].hs) begin
                hs_rises++;
                if (samples[i].vs) vs_lines++;
            end
            if (samples[i].vs && !samples[i-1].vs) begin
                if (seen) begin
                    check_count("hsync rises per frame", FRAME_LINES, hs_rises);
                    frames++;
                end
                seen     = 1'b1;
                hs_rises = 0;
                vs_lines = 0;
            end else if (!samples[i].vs && samples[i-1].vs && seen) begin
                check_count("vsync width in lines", V_SYNC_WIDTH, vs_lines);
            end
        end
        if (frames == 0) report_problem("Frame test saw fewer than two vsync pulses");
    endtask

    task automatic display_enable_counts();
        int run;
        int frame_de;
        int frames;
        bit started;
        bit seen;
        run      = 0;
        frame_de = 0;
        frames   = 0;
        started  = 1'b0;
        seen     = 1'b0;
        collect_frames(FRAMES_PER_TEST);
        for (int i = 1; i < samples.size(); i++) begin
            if (samples[i].vs && !samples[i-1].vs) begin
                if (seen) begin
                    check_count("de ticks per frame",
                                H_DISPLAYED * V_DISPLAYED * (MAX_SCAN + 1), frame_de);
                    frames++;
                end
                seen     = 1'b1;
                frame_de = 0;
            end
            if (samples[i].de) begin
                frame_de++;
                if (started) run++;
            end else begin
                // Only whole runs count as displayed lines
                if (started && run > 0) check_count("de ticks per line", H_DISPLAYED, run);
                started = 1'b1;
                run     = 0;
            end
        end
        if (frames == 0) report_problem("Display enable test saw no complete frame");
    endtask

    task automatic address_sequence();
        int                        vs_rise;
        int                        first;
        int                        row;
        sample_t                   s;
        logic [`CRTC_MA_WIDTH-1:0] exp_ma;
        vs_rise = -1;
        collect_frames(FRAMES_PER_TEST);
        for (int i = 1; i < samples.size() && vs_rise < 0; i++) begin
            if (samples[i].vs && !samples[i-1].vs) vs_rise = i;
        end
        // Lines from the vsync row to the end of that frame
        first = vs_rise + LINE_TICKS * ((V_TOTAL + 1 - V_SYNC_POS) * (MAX_SCAN + 1) + V_ADJUST);
        if (vs_rise < 0 || first + FRAME_TICKS > samples.size()) begin
            report_problem("Address test did not capture a complete settled frame");
        end else begin
            s = samples[first];
            check_count("de_o at frame start", 1, s.de);
            check_addr("ma_o at first de", START_ADDR, s.ma);
            check_count("ra_o at first de", 0, s.ra);
            for (int ln = 0; ln < FRAME_LINES; ln++) begin
                for (int c = 0; c < LINE_TICKS; c++) begin
                    s = samples[first + ln * LINE_TICKS + c];
                    if (ln < ROW_LINES) begin
                        row = ln / (MAX_SCAN + 1);
                        check_count("ra_o", ln % (MAX_SCAN + 1), s.ra);
                        if (row < V_DISPLAYED && c < H_DISPLAYED) begin
                            exp_ma = START_ADDR + `CRTC_MA_WIDTH'(row * H_DISPLAYED + c);
                            check_addr($sformatf("ma_o row %0d char %0d", row, c), exp_ma, s.ma);
                        end
                    end else begin
                        check_count("ra_o in adjust", ln - ROW_LINES, s.ra);
                    end
                end
            end
        end
    endtask

    initial begin
        reset_i  = 1'b1;
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        wb_adr_i = '0;
        wb_dat_i = '0;
        repeat (5) @(posedge wb_clock_i);
        reset_i <= 1'b0;
        @(posedge wb_clock_i);

        register_access();
        program_layout();   // Counters still at 0 before the first tick
        ticking <= 1'b1;
        line_timing();
        frame_timing();
        display_enable_counts();
        address_sequence();

        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS + 10 * CLK_PERIOD);
        n_errors++;
        $display("Timeout: the tests did not finish in time");
        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* include/crtc_cfg.svh */
// Build-time constants for the CRTC timing generator
// Included by the register package, the register file and the video stages
// Reset values give a 40 x 25 character layout with 8 scan lines per row

`ifndef CRTC_CFG_SVH
`define CRTC_CFG_SVH

`define CRTC_DATA_WIDTH 8           // Wishbone data bus
`define CRTC_ADDR_WIDTH 4           // Wishbone register address
`define CRTC_REG_COUNT  16          // Register slots behind the address
`define CRTC_MA_WIDTH   14          // Refresh memory address
`define CRTC_RA_WIDTH   5           // Raster address

`define CRTC_R0_RESET   8'h31       // 50 chars per line
`define CRTC_R1_RESET   8'h28       // 40 displayed
`define CRTC_R2_RESET   8'h29
`define CRTC_R3_RESET   8'h48       // Vsync 4 lines, hsync 8 chars
`define CRTC_R4_RESET   8'h20       // 33 rows per frame
`define CRTC_R5_RESET   8'h05
`define CRTC_R6_RESET   8'h19       // 25 displayed
`define CRTC_R7_RESET   8'h1C
`define CRTC_R9_RESET   8'h07       // 8 scan lines per row
`define CRTC_R12_RESET  8'h00
`define CRTC_R13_RESET  8'h00

`endif

/* source/crtc_addr_gen.sv */
// Address stage of the CRTC pipeline
// Keeps the refresh address of each character and the base of the current
// row, and registers the video outputs on each tick
// Adds one cycle, so the outputs lag clk_en_i by three cycles

`default_nettype none

`include "crtc_cfg.svh"

module crtc_addr_gen
    import crtc_regs_pkg::*, crtc_timing_pkg::*;
(
    input  logic                      wb_clock_i,
    input  logic                      reset_i,
    input  crtc_cfg_t                 cfg_i,
    input  v_timing_t                 v_i,
    output logic                      h_sync_o,
    output logic                      v_sync_o,
    output logic                      de_o,
    output logic [`CRTC_MA_WIDTH-1:0] ma_o,
    output logic [`CRTC_RA_WIDTH-1:0] ra_o
);
    logic [`CRTC_MA_WIDTH-1:0] ma_q;         // Address of the current character
    logic [`CRTC_MA_WIDTH-1:0] row_base_q;   // First address of the current row
    logic [`CRTC_MA_WIDTH-1:0] next_base;

    // Next row starts one displayed line further on, wrapping at 14 bits
    assign next_base = v_i.row_end ? row_base_q + `CRTC_MA_WIDTH'(cfg_i.h_displayed)
                                   : row_base_q;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            h_sync_o   <= 1'b0;
            v_sync_o   <= 1'b0;
            de_o       <= 1'b0;
            ma_o       <= '0;
            ra_o       <= '0;
            ma_q       <= '0;
            row_base_q <= '0;
        end else if (v_i.tick) begin
            h_sync_o <= v_i.h_sync;
            v_sync_o <= v_i.v_sync;
            de_o     <= v_i.h_de && v_i.v_de;
            ra_o     <= v_i.ra;
            ma_o     <= ma_q;

            if (v_i.frame_start) begin       // Wins over the line end it comes with
                ma_q       <= cfg_i.start_addr;
                row_base_q <= cfg_i.start_addr;
            end else if (v_i.line_end) begin
                ma_q       <= next_base;
                row_base_q <= next_base;
            end else if (v_i.h_de) begin
                ma_q <= ma_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/crtc_horiz.sv */
// Horizontal stage of the CRTC pipeline
// Counts characters on each clock enable and registers line end,
// horizontal display and horizontal sync for that character tick
// Output lags clk_en_i by one cycle

`default_nettype none

module crtc_horiz
    import crtc_regs_pkg::*, crtc_timing_pkg::*;
(
    input  logic      wb_clock_i,
    input  logic      reset_i,
    input  logic      clk_en_i,
    input  crtc_cfg_t cfg_i,
    output h_timing_t h_o
);
    logic [7:0] char_q;         // Character position in the line
    logic [3:0] hs_left_q;      // Sync ticks still to come after the current one
    logic       at_end;
    logic       at_sync;

    assign at_end  = char_q == cfg_i.h_total;
    assign at_sync = char_q == cfg_i.h_sync_pos;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            char_q    <= '0;
            hs_left_q <= '0;
            h_o       <= '0;
        end else begin
            h_o.tick <= clk_en_i;

            // Other fields hold between ticks
            if (clk_en_i) begin
                h_o.line_end <= at_end;
                h_o.h_de     <= char_q < cfg_i.h_displayed;
                h_o.h_sync   <= at_sync || (hs_left_q != '0);

                if (at_end) char_q <= '0;
                else        char_q <= char_q + 8'd1;   // Also wraps if h_total shrinks

                if (at_sync) begin
                    hs_left_q <= cfg_i.h_sync_width - 4'd1;
                end else if (hs_left_q != '0) begin
                    hs_left_q <= hs_left_q - 4'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/crtc_reg_file.sv */
// Wishbone classic register port of the CRTC
// One access takes two cycles: ack one cycle after the strobe, then a gap
// Written values are masked to the register width, unused slots read 0
// The registers are presented decoded on cfg_o for the video stages

`default_nettype none

`include "crtc_cfg.svh"

module crtc_reg_file
    import crtc_regs_pkg::*;
(
    input  logic                       wb_clock_i,
    input  logic                       reset_i,
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [`CRTC_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [`CRTC_DATA_WIDTH-1:0] wb_dat_i,
    output logic [`CRTC_DATA_WIDTH-1:0] wb_dat_o,
    output logic                       wb_ack_o,
    output crtc_cfg_t                  cfg_o
);
    logic [`CRTC_DATA_WIDTH-1:0] regs_q [`CRTC_REG_COUNT];
    logic                        accept;

    // Implemented bits per register, unused slots have none
    function automatic logic [`CRTC_DATA_WIDTH-1:0] reg_mask(input crtc_reg_e idx);
        case (idx)
            R0_H_TOTAL, R1_H_DISPLAYED, R2_H_SYNC_POS, R3_SYNC_WIDTH: reg_mask = 8'hFF;
            R4_V_TOTAL, R6_V_DISPLAYED, R7_V_SYNC_POS:                reg_mask = 8'h7F;
            R5_V_ADJUST, R9_MAX_SCAN:                                 reg_mask = 8'h1F;
            R12_START_HI:                                             reg_mask = 8'h3F;
            R13_START_LO:                                             reg_mask = 8'hFF;
            default:                                                  reg_mask = 8'h00;
        endcase
    endfunction

    function automatic logic [`CRTC_DATA_WIDTH-1:0] reg_reset(input crtc_reg_e idx);
        case (idx)
            R0_H_TOTAL:     reg_reset = `CRTC_R0_RESET;
            R1_H_DISPLAYED: reg_reset = `CRTC_R1_RESET;
            R2_H_SYNC_POS:  reg_reset = `CRTC_R2_RESET;
            R3_SYNC_WIDTH:  reg_reset = `CRTC_R3_RESET;
            R4_V_TOTAL:     reg_reset = `CRTC_R4_RESET;
            R5_V_ADJUST:    reg_reset = `CRTC_R5_RESET;
            R6_V_DISPLAYED: reg_reset = `CRTC_R6_RESET;
            R7_V_SYNC_POS:  reg_reset = `CRTC_R7_RESET;
            R9_MAX_SCAN:    reg_reset = `CRTC_R9_RESET;
            R12_START_HI:   reg_reset = `CRTC_R12_RESET;
            R13_START_LO:   reg_reset = `CRTC_R13_RESET;
            default:        reg_reset = '0;
        endcase
    endfunction

    assign accept = wb_cyc_i && wb_stb_i && !wb_ack_o;   // Gap cycle after each ack

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            wb_ack_o <= 1'b0;
            for (int i = 0; i < `CRTC_REG_COUNT; i++) begin
                regs_q[i] <= reg_reset(crtc_reg_e'(i[`CRTC_ADDR_WIDTH-1:0]));
            end
        end else begin
            wb_ack_o <= accept;
            if (accept && wb_we_i) begin
                regs_q[wb_adr_i] <= wb_dat_i & reg_mask(crtc_reg_e'(wb_adr_i));
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge wb_clock_i) begin
        if (accept) wb_dat_o <= regs_q[wb_adr_i];
    end

    always_comb begin
        cfg_o.h_total      = regs_q[R0_H_TOTAL];
        cfg_o.h_displayed  = regs_q[R1_H_DISPLAYED];
        cfg_o.h_sync_pos   = regs_q[R2_H_SYNC_POS];
        cfg_o.h_sync_width = regs_q[R3_SYNC_WIDTH][3:0];
        cfg_o.v_sync_width = regs_q[R3_SYNC_WIDTH][7:4];
        cfg_o.v_total      = regs_q[R4_V_TOTAL][6:0];
        cfg_o.v_adjust     = regs_q[R5_V_ADJUST][4:0];
        cfg_o.v_displayed  = regs_q[R6_V_DISPLAYED][6:0];
        cfg_o.v_sync_pos   = regs_q[R7_V_SYNC_POS][6:0];
        cfg_o.max_scan     = regs_q[R9_MAX_SCAN][4:0];
        cfg_o.start_addr   = {regs_q[R12_START_HI][5:0], regs_q[R13_START_LO]};
    end

endmodule

`default_nettype wire

/* source/crtc_regs_pkg.sv */
// Register-side types of the CRTC
// Holds the register index encoding and the decoded timing configuration
// which the register file drives into every pipeline stage

`default_nettype none

`include "crtc_cfg.svh"

package crtc_regs_pkg;

    // Wishbone address of each implemented register
    typedef enum logic [`CRTC_ADDR_WIDTH-1:0] {
        R0_H_TOTAL     = 4'd0,
        R1_H_DISPLAYED = 4'd1,
        R2_H_SYNC_POS  = 4'd2,
        R3_SYNC_WIDTH  = 4'd3,
        R4_V_TOTAL     = 4'd4,
        R5_V_ADJUST    = 4'd5,
        R6_V_DISPLAYED = 4'd6,
        R7_V_SYNC_POS  = 4'd7,
        R9_MAX_SCAN    = 4'd9,
        R12_START_HI   = 4'd12,
        R13_START_LO   = 4'd13
    } crtc_reg_e;

    typedef struct packed {
        logic [7:0]                    h_total;         // Chars per line minus one
        logic [7:0]                    h_displayed;
        logic [7:0]                    h_sync_pos;
        logic [3:0]                    h_sync_width;    // In character ticks
        logic [3:0]                    v_sync_width;    // In scan lines
        logic [6:0]                    v_total;         // Rows per frame minus one
        logic [4:0]                    v_adjust;
        logic [6:0]                    v_displayed;
        logic [6:0]                    v_sync_pos;
        logic [4:0]                    max_scan;        // Scan lines per row minus one
        logic [`CRTC_MA_WIDTH-1:0]     start_addr;
    } crtc_cfg_t;

endpackage

`default_nettype wire

/* source/crtc_timing_pkg.sv */
// Pipeline-side types of the CRTC
// Each stage registers one of these structs towards the next stage
// The tick field is the character clock enable travelling with its data

`default_nettype none

`include "crtc_cfg.svh"

package crtc_timing_pkg;

    // Main rows of a frame, then the vertical adjust scan lines
    typedef enum logic {
        ROWS   = 1'b0,
        ADJUST = 1'b1
    } frame_state_e;

    typedef struct packed {
        logic tick;             // Fields below belong to a character tick
        logic line_end;         // Last character of the line
        logic h_de;
        logic h_sync;
    } h_timing_t;

    typedef struct packed {
        logic                      tick;
        logic                      line_end;
        logic                      h_de;
        logic                      h_sync;
        logic                      v_de;
        logic                      v_sync;
        logic [`CRTC_RA_WIDTH-1:0] ra;
        logic                      frame_start;  // Last line end of the frame
        logic                      row_end;      // Last line end of a character row
    } v_timing_t;

endpackage

`default_nettype wire

/* source/crtc_top.sv */
// Top level of the CRTC timing generator
// Wishbone register file feeding a three stage video pipeline:
// horizontal, vertical and address
// Video outputs lag clk_en_i by a fixed three cycles

`default_nettype none

`include "crtc_cfg.svh"

module crtc_top
    import crtc_regs_pkg::*, crtc_timing_pkg::*;
(
    input  logic                        wb_clock_i,
    input  logic                        reset_i,
    input  logic                        clk_en_i,       // Character clock enable
    input  logic                        wb_cyc_i,
    input  logic                        wb_stb_i,
    input  logic                        wb_we_i,
    input  logic [`CRTC_ADDR_WIDTH-1:0] wb_adr_i,
    input  logic [`CRTC_DATA_WIDTH-1:0] wb_dat_i,
    output logic [`CRTC_DATA_WIDTH-1:0] wb_dat_o,
    output logic                        wb_ack_o,
    output logic                        h_sync_o,
    output logic                        v_sync_o,
    output logic                        de_o,
    output logic [`CRTC_MA_WIDTH-1:0]   ma_o,
    output logic [`CRTC_RA_WIDTH-1:0]   ra_o
);
    crtc_cfg_t cfg;
    h_timing_t h_tim;
    v_timing_t v_tim;

    crtc_reg_file reg_file0 (
        .wb_clock_i, .reset_i, .wb_cyc_i, .wb_stb_i, .wb_we_i,
        .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
        .cfg_o      (cfg)
    );

    crtc_horiz horiz0 (
        .wb_clock_i, .reset_i, .clk_en_i,
        .cfg_i      (cfg),
        .h_o        (h_tim)
    );

    crtc_vert vert0 (
        .wb_clock_i, .reset_i,
        .cfg_i      (cfg),
        .h_i        (h_tim),
        .v_o        (v_tim)
    );

    crtc_addr_gen addr_gen0 (
        .wb_clock_i, .reset_i,
        .cfg_i      (cfg),
        .v_i        (v_tim),
        .h_sync_o, .v_sync_o, .de_o, .ma_o, .ra_o
    );

endmodule

`default_nettype wire

/* source/crtc_vert.sv */
// Vertical stage of the CRTC pipeline
// Counts scan lines, character rows and adjust lines at each line end
// and registers vertical display, vertical sync and the raster address
// next to the horizontal fields of the same tick
// Adds one cycle to the pipeline

`default_nettype none

module crtc_vert
    import crtc_regs_pkg::*, crtc_timing_pkg::*;
(
    input  logic      wb_clock_i,
    input  logic      reset_i,
    input  crtc_cfg_t cfg_i,
    input  h_timing_t h_i,
    output v_timing_t v_o
);
    frame_state_e state_q;
    logic [4:0]   ra_q;         // Scan line within the row
    logic [6:0]   row_q;
    logic [4:0]   adj_q;        // Line within the adjust period
    logic [3:0]   vs_left_q;    // Sync lines still to come after the current one
    logic         in_rows;
    logic         last_line;
    logic         last_row;
    logic         adj_done;
    logic         frame_end;
    logic         vs_start;

    assign in_rows   = state_q == ROWS;
    assign last_line = ra_q == cfg_i.max_scan;
    assign last_row  = row_q == cfg_i.v_total;
    assign adj_done  = ({1'b0, adj_q} + 6'd1) >= {1'b0, cfg_i.v_adjust};

    // True for the whole last scan line of the frame
    assign frame_end = in_rows ? (last_line && last_row && cfg_i.v_adjust == '0) : adj_done;
    assign vs_start  = in_rows && row_q == cfg_i.v_sync_pos && ra_q == '0;

    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            v_o <= '0;
        end else begin
            v_o.tick <= h_i.tick;
            if (h_i.tick) begin
                v_o.line_end    <= h_i.line_end;
                v_o.h_de        <= h_i.h_de;
                v_o.h_sync      <= h_i.h_sync;
                v_o.v_de        <= in_rows && row_q < cfg_i.v_displayed;
                v_o.v_sync      <= vs_start || (vs_left_q != '0);
                v_o.ra          <= in_rows ? ra_q : adj_q;
                v_o.frame_start <= h_i.line_end && frame_end;
                v_o.row_end     <= h_i.line_end && in_rows && last_line;
            end
        end
    end

    // Frame FSM and counters move only at line ends
    always_ff @(posedge wb_clock_i) begin
        if (reset_i) begin
            state_q   <= ROWS;
            ra_q      <= '0;
            row_q     <= '0;
            adj_q     <= '0;
            vs_left_q <= '0;
        end else if (h_i.tick && h_i.line_end) begin
            if (frame_end) begin
                state_q <= ROWS;
                ra_q    <= '0;
                row_q   <= '0;
                adj_q   <= '0;
            end else begin
                case (state_q)
                    ROWS: begin
                        if (!last_line) begin
                            ra_q <= ra_q + 5'd1;
                        end else begin
                            ra_q <= '0;
                            if (last_row) begin
                                state_q <= ADJUST;
                                adj_q   <= '0;
                            end else begin
                                row_q <= row_q + 7'd1;
                            end
                        end
                    end
                    ADJUST:  adj_q <= adj_q + 5'd1;
                    default: state_q <= ROWS;
                endcase
            end

            if (vs_start) begin
                vs_left_q <= cfg_i.v_sync_width - 4'd1;
            end else if (vs_left_q != '0) begin
                vs_left_q <= vs_left_q - 4'd1;
            end
        end
    end

endmodule

`default_nettype wire
